// File: hw/uart_line_pkg.sv
// uart line package, character width and serial timing vector types
package uart_line_pkg;

    // data bits per 8N1 frame, fixed because the beat struct width follows it
    localparam int unsigned DATA_BITS = 8;

    // width of the clocks-per-bit divider count
    localparam int unsigned BAUD_CNT_W = 16;

    // width of the data bit index
    localparam int unsigned BIT_IDX_W = $clog2(DATA_BITS);

    // one character as it travels on the line
    typedef logic [DATA_BITS-1:0] uart_byte_t;

    // clocks-per-bit divider count
    typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;

    // selects one data bit within a frame
    typedef logic [BIT_IDX_W-1:0] bit_idx_t;

endpackage

// File: hw/uart_stream_pkg.sv
// uart stream package, received beat layout and buffer pointer type
package uart_stream_pkg;

    import uart_line_pkg::*;

    // one received character with its stop-bit check
    typedef struct packed {
        uart_byte_t data;
        logic       frame_err; // stop bit sampled low
    } rx_beat_t;

    // buffer pointer, covers depths up to 16 plus the wrap bit
    localparam int unsigned FIFO_PTR_W = 5;

    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

endpackage

// File: hw/uart_rx.sv
// uart receiver, samples 8N1 frames at bit centres and emits checked byte beats
`timescale 1ns/1ps

module uart_rx
    import uart_line_pkg::*;
    import uart_stream_pkg::*;
#(
    parameter int unsigned CLK_FREQ  = 125_000_000,
    parameter int unsigned BAUD_RATE = 115_200
) (
    input  logic     clk_i,
    input  logic     arstn_i,
    input  logic     uart_rx_i,
    output rx_beat_t beat_o,
    output logic     valid_o,
    input  logic     ready_i,
    output logic     drop_o
);

    localparam int unsigned CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam baud_cnt_t   BIT_LAST     = baud_cnt_t'(CLKS_PER_BIT - 1);
    localparam baud_cnt_t   HALF_LAST    = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);
    localparam bit_idx_t    IDX_LAST     = bit_idx_t'(DATA_BITS - 1);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_HOLD
    } rx_state_e;

    rx_state_e  state_q;
    rx_state_e  state_d;
    logic       rx_meta_q;
    logic       rx_sync_q;
    baud_cnt_t  baud_cnt_q;
    bit_idx_t   bit_idx_q;
    uart_byte_t data_q;
    logic       stop_q;
    rx_beat_t   beat_q;
    logic       valid_q;
    logic       drop_q;
    logic       half_end;
    logic       bit_end;
    logic       cnt_clr;
    logic       load_beat;

    assign half_end  = (state_q == RX_START) && (baud_cnt_q == HALF_LAST); // start bit centre
    assign bit_end   = (baud_cnt_q == BIT_LAST);
    assign cnt_clr   = (state_q == RX_IDLE) || (state_q == RX_HOLD) || half_end || bit_end;
    assign load_beat = (state_q == RX_HOLD) && (!valid_q || ready_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            RX_IDLE: begin
                if (!rx_sync_q) begin
                    state_d = RX_START;
                end
            end
            RX_START: begin
                if (half_end) begin
                    state_d = rx_sync_q ? RX_IDLE : RX_DATA; // glitch returns to idle
                end
            end
            RX_DATA: begin
                if (bit_end && (bit_idx_q == IDX_LAST)) begin
                    state_d = RX_STOP;
                end
            end
            RX_STOP: begin
                if (bit_end) begin
                    state_d = RX_HOLD;
                end
            end
            default: state_d = RX_IDLE; // hold lasts one cycle
        endcase
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rx_meta_q  <= 1'b1; // line idles high
            rx_sync_q  <= 1'b1;
            state_q    <= RX_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            valid_q    <= 1'b0;
            drop_q     <= 1'b0;
        end else begin
            rx_meta_q <= uart_rx_i;
            rx_sync_q <= rx_meta_q;
            state_q   <= state_d;
            if (cnt_clr) begin
                baud_cnt_q <= '0;
            end else begin
                baud_cnt_q <= baud_cnt_q + baud_cnt_t'(1);
            end
            if (half_end) begin
                bit_idx_q <= '0;
            end else if ((state_q == RX_DATA) && bit_end) begin
                bit_idx_q <= bit_idx_q + bit_idx_t'(1);
            end
            if (load_beat) begin
                valid_q <= 1'b1;
            end else if (ready_i) begin
                valid_q <= 1'b0;
            end
            drop_q <= (state_q == RX_HOLD) && !load_beat; // beat register still full
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == RX_DATA) && bit_end) begin
            data_q[bit_idx_q] <= rx_sync_q; // lsb first
        end
        if ((state_q == RX_STOP) && bit_end) begin
            stop_q <= rx_sync_q;
        end
        if (load_beat) begin
            beat_q.data      <= data_q;
            beat_q.frame_err <= ~stop_q;
        end
    end

    assign beat_o  = beat_q;
    assign valid_o = valid_q;
    assign drop_o  = drop_q;

endmodule

// File: hw/uart_tx.sv
// uart transmitter, serialises host bytes into 8N1 frames
`timescale 1ns/1ps

module uart_tx
    import uart_line_pkg::*;
#(
    parameter int unsigned CLK_FREQ  = 125_000_000,
    parameter int unsigned BAUD_RATE = 115_200
) (
    input  logic       clk_i,
    input  logic       arstn_i,
    input  uart_byte_t byte_i,
    input  logic       valid_i,
    output logic       ready_o,
    output logic       uart_tx_o
);

    localparam int unsigned CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam baud_cnt_t   BIT_LAST     = baud_cnt_t'(CLKS_PER_BIT - 1);
    localparam bit_idx_t    IDX_LAST     = bit_idx_t'(DATA_BITS - 1);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    tx_state_e  state_q;
    tx_state_e  state_d;
    baud_cnt_t  baud_cnt_q;
    bit_idx_t   bit_idx_q;
    uart_byte_t shift_q;
    logic       tx_q;
    logic       bit_end;
    logic       accept;

    assign bit_end = (baud_cnt_q == BIT_LAST);
    assign accept  = (state_q == TX_IDLE) && valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            TX_IDLE:  if (valid_i) state_d = TX_START;
            TX_START: if (bit_end) state_d = TX_DATA;
            TX_DATA:  if (bit_end && (bit_idx_q == IDX_LAST)) state_d = TX_STOP;
            default:  if (bit_end) state_d = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state_q    <= TX_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            tx_q       <= 1'b1; // line idles high
        end else begin
            state_q <= state_d;
            if ((state_q == TX_IDLE) || bit_end) begin
                baud_cnt_q <= '0;
            end else begin
                baud_cnt_q <= baud_cnt_q + baud_cnt_t'(1);
            end
            if (accept) begin
                tx_q      <= 1'b0; // start bit
                bit_idx_q <= '0;
            end else if ((state_q == TX_START) && bit_end) begin
                tx_q <= shift_q[0];
            end else if ((state_q == TX_DATA) && bit_end) begin
                tx_q      <= (bit_idx_q == IDX_LAST) ? 1'b1 : shift_q[1]; // stop bit after last
                bit_idx_q <= bit_idx_q + bit_idx_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            shift_q <= byte_i;
        end else if ((state_q == TX_DATA) && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign ready_o   = (state_q == TX_IDLE);
    assign uart_tx_o = tx_q;

endmodule

// File: hw/rx_byte_fifo.sv
// receive buffer, circular FIFO of byte beats with a sticky overrun flag
`timescale 1ns/1ps

module rx_byte_fifo
    import uart_stream_pkg::*;
#(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic     clk_i,
    input  logic     arstn_i,
    input  rx_beat_t wr_beat_i,
    input  logic     wr_valid_i,
    output logic     wr_ready_o,
    input  logic     drop_i,
    output rx_beat_t rd_beat_o,
    output logic     rd_valid_o,
    input  logic     rd_ready_i,
    output logic     overrun_o
);

    localparam int unsigned AW = $clog2(FIFO_DEPTH);

    rx_beat_t  mem_q [FIFO_DEPTH];
    fifo_ptr_t wr_ptr_q;
    fifo_ptr_t rd_ptr_q;
    logic      full;
    logic      empty;
    logic      push;
    logic      pop;
    logic      overrun_q;

    // wrap bit differs and addresses match when full
    assign full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) && (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
    assign empty = (wr_ptr_q[AW:0] == rd_ptr_q[AW:0]);
    assign push  = wr_valid_i && !full;
    assign pop   = rd_ready_i && !empty;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            overrun_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + fifo_ptr_t'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + fifo_ptr_t'(1);
            end
            if (drop_i) begin
                overrun_q <= 1'b1; // sticky until reset
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q[AW-1:0]] <= wr_beat_i;
        end
    end

    assign wr_ready_o = !full;
    assign rd_beat_o  = mem_q[rd_ptr_q[AW-1:0]];
    assign rd_valid_o = !empty;
    assign overrun_o  = overrun_q;

endmodule

// File: hw/uart_bridge_top.sv
// uart bridge top, links receiver, receive FIFO and transmitter to the host streams
`timescale 1ns/1ps

module uart_bridge_top
    import uart_line_pkg::*;
    import uart_stream_pkg::*;
#(
    parameter int unsigned CLK_FREQ   = 125_000_000,
    parameter int unsigned BAUD_RATE  = 115_200,
    parameter int unsigned FIFO_DEPTH = 4 // power of two, at most 16
) (
    input  logic       clk_i,
    input  logic       arstn_i,
    input  logic       uart_rx_i,
    output logic       uart_tx_o,
    output rx_beat_t   host_rx_o,
    output logic       host_rx_valid_o,
    input  logic       host_rx_ready_i,
    input  uart_byte_t host_tx_i,
    input  logic       host_tx_valid_i,
    output logic       host_tx_ready_o,
    output logic       rx_overrun_o
);

    rx_beat_t rx_beat;
    logic     rx_valid;
    logic     rx_ready;
    logic     rx_drop;

    uart_rx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) i_uart_rx (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .uart_rx_i (uart_rx_i),
        .beat_o    (rx_beat),
        .valid_o   (rx_valid),
        .ready_i   (rx_ready),
        .drop_o    (rx_drop)
    );

    rx_byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_rx_byte_fifo (
        .clk_i      (clk_i),
        .arstn_i    (arstn_i),
        .wr_beat_i  (rx_beat),
        .wr_valid_i (rx_valid),
        .wr_ready_o (rx_ready),
        .drop_i     (rx_drop),
        .rd_beat_o  (host_rx_o),
        .rd_valid_o (host_rx_valid_o),
        .rd_ready_i (host_rx_ready_i),
        .overrun_o  (rx_overrun_o)
    );

    uart_tx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) i_uart_tx (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .byte_i    (host_tx_i),
        .valid_i   (host_tx_valid_i),
        .ready_o   (host_tx_ready_o),
        .uart_tx_o (uart_tx_o)
    );

endmodule

// File: bench/tb_uart_bridge.sv
// testbench for the uart bridge that drives serial frames and host streams and checks them
`timescale 1ns/1ps

module tb_uart_bridge
    import uart_line_pkg::*;
    import uart_stream_pkg::*;
();

    localparam int unsigned CLK_FREQ    = 125_000_000;
    localparam int unsigned BAUD_RATE   = 7_812_500;
    localparam int unsigned CPB         = CLK_FREQ / BAUD_RATE; // 16 clocks per bit
    localparam int unsigned N_RAND      = 8;
    localparam int unsigned NUM_FRAMES  = 5 * N_RAND + 8;
    localparam int unsigned CYCLE_LIMIT = NUM_FRAMES * 10 * CPB * 2 + 2000;
    localparam logic [31:0] SEED        = 32'ha4d5_4b29;

    logic        clk_i;
    logic        arstn_i;
    logic        uart_rx_i;
    logic        uart_tx_o;
    rx_beat_t    host_rx_o;
    logic        host_rx_valid_o;
    logic        host_rx_ready_i;
    uart_byte_t  host_tx_i;
    logic        host_tx_valid_i;
    logic        host_tx_ready_o;
    logic        rx_overrun_o;
    rx_beat_t    rx_exp_q[$];
    uart_byte_t  tx_exp_q[$];
    logic [31:0] rng_state;
    logic [1:0]  ready_mode; // 0 always ready, 1 random stalls, 2 held low
    string       test_name;
    int unsigned cycle_cnt;

    uart_bridge_top #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE), .FIFO_DEPTH(4)) i_dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // beat that a correct receiver builds from the sent byte and the stop level
    function automatic rx_beat_t expected_beat(input uart_byte_t data, input logic stop_level);
        rx_beat_t beat;
        beat.data      = data;
        beat.frame_err = ~stop_level;
        return beat;
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_beat(input rx_beat_t exp, input rx_beat_t got);
        if (exp !== got) begin
            report_failure($sformatf(
                "ERR %s: expected data %h frame_err %b, actual data %h frame_err %b",
                test_name, exp.data, exp.frame_err, got.data, got.frame_err));
        end
    endtask

    task automatic check_byte(input uart_byte_t exp, input uart_byte_t got);
        if (exp !== got) begin
            report_failure($sformatf("ERR %s: expected %h, actual %h", test_name, exp, got));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic got);
        if (exp !== got) begin
            report_failure($sformatf("ERR %s %s: expected %b, actual %b",
                test_name, what, exp, got));
        end
    endtask

    task automatic send_frame(input uart_byte_t data, input logic stop_level, input logic kept);
        logic [9:0] bits;
        int         i;
        bits = {stop_level, data, 1'b0}; // start bit first, lsb first
        if (kept) begin
            rx_exp_q.push_back(expected_beat(data, stop_level));
        end
        @(posedge clk_i);
        #1;
        for (i = 0; i < 10; i++) begin
            uart_rx_i = bits[i];
            repeat (CPB) @(posedge clk_i);
            #1;
        end
        uart_rx_i = 1'b1;
    endtask

    task automatic send_tx(input uart_byte_t data);
        tx_exp_q.push_back(data);
        @(posedge clk_i);
        #1;
        host_tx_i       = data;
        host_tx_valid_i = 1'b1;
        do begin
            @(posedge clk_i);
        end while (!host_tx_ready_o);
        #1;
        host_tx_valid_i = 1'b0;
    endtask

    task automatic wait_drained();
        do begin
            @(posedge clk_i);
            #1;
        end while ((rx_exp_q.size() != 0) || (tx_exp_q.size() != 0));
    endtask

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin : cycle_watchdog
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        report_failure($sformatf("timeout after %0d cycles, the tests did not finish",
            CYCLE_LIMIT));
    end

    initial begin : host_ready_model
        logic [31:0] stall_state;
        logic        next_ready;
        stall_state     = xorshift32(SEED);
        host_rx_ready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            stall_state = xorshift32(stall_state);
            next_ready  = (ready_mode == 2'd0) || ((ready_mode == 2'd1) && stall_state[3]);
            #1;
            host_rx_ready_i = next_ready;
        end
    end

    initial begin : rx_compare
        forever begin
            @(posedge clk_i);
            if (arstn_i && host_rx_valid_o && host_rx_ready_i) begin
                if (rx_exp_q.size() == 0) begin
                    report_failure("a beat appeared on the host receive stream that was never sent");
                end else begin
                    check_beat(rx_exp_q.pop_front(), host_rx_o);
                end
            end
        end
    end

    initial begin : tx_monitor
        uart_byte_t got;
        int         b;
        forever begin
            @(negedge uart_tx_o);
            repeat (CPB / 2) @(posedge clk_i); // centre of the start bit
            check_flag("tx start bit", 1'b0, uart_tx_o);
            check_flag("host_tx_ready_o in frame", 1'b0, host_tx_ready_o);
            for (b = 0; b < DATA_BITS; b++) begin
                repeat (CPB) @(posedge clk_i);
                got[b] = uart_tx_o;
                check_flag("host_tx_ready_o in frame", 1'b0, host_tx_ready_o);
            end
            repeat (CPB) @(posedge clk_i);
            check_flag("tx stop bit", 1'b1, uart_tx_o);
            check_flag("host_tx_ready_o in frame", 1'b0, host_tx_ready_o);
            if (tx_exp_q.size() == 0) begin
                report_failure("the tx line carried a frame that the host never offered");
            end else begin
                check_byte(tx_exp_q.pop_front(), got);
            end
        end
    end

    initial begin : main_sequence
        int i;
        int k;
        arstn_i         = 1'b0;
        uart_rx_i       = 1'b1;
        host_tx_i       = '0;
        host_tx_valid_i = 1'b0;
        ready_mode      = 2'd0;
        rng_state       = SEED;
        test_name       = "reset";
        repeat (4) @(posedge clk_i);
        #1;
        arstn_i = 1'b1;
        check_flag("host_rx_valid_o", 1'b0, host_rx_valid_o);
        check_flag("rx_overrun_o", 1'b0, rx_overrun_o);
        check_flag("uart_tx_o", 1'b1, uart_tx_o);
        check_flag("host_tx_ready_o", 1'b1, host_tx_ready_o);

        test_name = "rx_random";
        for (i = 0; i < N_RAND; i++) begin
            rng_state = xorshift32(rng_state);
            send_frame(rng_state[7:0], 1'b1, 1'b1);
        end
        wait_drained();

        test_name = "rx_framing";
        rng_state = xorshift32(rng_state);
        send_frame(rng_state[7:0], 1'b0, 1'b1); // stop bit held low
        repeat (2 * CPB) @(posedge clk_i);
        #1;
        uart_rx_i = 1'b0; // start pulse well under half a bit
        repeat (CPB / 4) @(posedge clk_i);
        #1;
        uart_rx_i = 1'b1;
        repeat (2 * CPB) @(posedge clk_i);
        send_frame(8'h96, 1'b1, 1'b1);
        wait_drained();

        test_name  = "rx_stall";
        ready_mode = 2'd1;
        for (i = 0; i < N_RAND; i++) begin
            rng_state = xorshift32(rng_state);
            send_frame(rng_state[7:0], 1'b1, 1'b1);
        end
        wait_drained();

        test_name  = "rx_overrun";
        check_flag("rx_overrun_o before overflow", 1'b0, rx_overrun_o);
        ready_mode = 2'd2;
        for (i = 0; i < 6; i++) begin
            rng_state = xorshift32(rng_state);
            send_frame(rng_state[7:0], 1'b1, i < 5); // four in the FIFO, one held, sixth lost
        end
        repeat (2 * CPB) @(posedge clk_i);
        #1;
        check_flag("rx_overrun_o", 1'b1, rx_overrun_o);
        ready_mode = 2'd0;
        wait_drained();

        test_name = "tx_loop";
        for (i = 0; i < N_RAND; i++) begin
            rng_state = xorshift32(rng_state);
            send_tx(rng_state[7:0]);
        end
        wait_drained();

        test_name = "rx_tx_mixed";
        fork
            for (i = 0; i < N_RAND; i++) begin
                rng_state = xorshift32(rng_state);
                send_frame(rng_state[7:0], 1'b1, 1'b1);
            end
            for (k = 0; k < N_RAND; k++) begin
                send_tx(uart_byte_t'(8'h5a ^ (k * 29)));
            end
        join
        wait_drained();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: sources.f
hw/uart_line_pkg.sv
hw/uart_stream_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/rx_byte_fifo.sv
hw/uart_bridge_top.sv
bench/tb_uart_bridge.sv

// File: Bender.yml
package:
  name: uart_bridge

sources:
  - files:
      - hw/uart_line_pkg.sv
      - hw/uart_stream_pkg.sv
  - files:
      - hw/uart_rx.sv
      - hw/uart_tx.sv
      - hw/rx_byte_fifo.sv
      - hw/uart_bridge_top.sv
  - target: test
    files:
      - bench/tb_uart_bridge.sv
